// ==== verilog/arp_dma_config.svh ====
// ====================
// Widths, FIFO depths and protocol constants
// of the ARP/DMA stream steering block
// ====================
`ifndef ARP_DMA_CONFIG_SVH
`define ARP_DMA_CONFIG_SVH

// Stream and register widths
`define DATA_WIDTH      128
`define USER_WIDTH      32
`define REG_WIDTH       32

// FIFO depth exponents
`define IN_DEPTH_BITS   2
`define DMA_DEPTH_BITS  6

// Packet classification
`define DMA_IDENT       8'hFF
`define ARP_TYPE        16'h0608
`define TYPE_LSB        96
`define SRC_PORT_LSB    16

// Metadata beat marker
`define META_MAGIC      32'hA5A5A5A5

`endif

// ==== verilog/stream_pkg.sv ====
// ====================
// Packet stream types
// Field vectors and the beat struct
// ====================
`include "arp_dma_config.svh"

package stream_pkg;

   // Beat payload and sideband
   typedef logic [`DATA_WIDTH-1:0]   data_t;
   typedef logic [`DATA_WIDTH/8-1:0] keep_t;
   typedef logic [`USER_WIDTH-1:0]   user_t;

   // Header fields used for steering
   typedef logic [7:0]  port_t;
   typedef logic [15:0] ether_type_t;

   // One stream beat as stored in the FIFOs
   typedef struct packed {
      logic  last;
      user_t user;
      keep_t keep;
      data_t data;
   } beat_t;

endpackage

// ==== verilog/ctrl_pkg.sv ====
// ====================
// Control types
// Register map, command and steering states
// ====================
`include "arp_dma_config.svh"

package ctrl_pkg;

   typedef logic [`REG_WIDTH-1:0] reg_word_t;

   typedef enum logic [1:0] {
      REG_SIZE    = 2'd0,
      REG_PKT_IN  = 2'd1,
      REG_PKT_OUT = 2'd2
   } reg_addr_e;

   // Host request held on reg_cmd during the handshake
   typedef struct packed {
      logic      write;
      reg_addr_e addr;
      reg_word_t wdata;
   } reg_cmd_t;

   typedef enum logic [2:0] {
      IDLE, ARP_META, ARP_PAYLOAD, DMA_STORE, PASS, DISCARD
   } steer_state_e;

endpackage

// ==== verilog/stream_fifo.sv ====
// ====================
// Fall-through FIFO of stream beats
// with nearly-full flag and write ready
// ====================
`timescale 1ns/1ps

module stream_fifo #(
   parameter int DEPTH_BITS = 2
) (
   input  logic              axis_aclk,
   input  logic              axis_resetn,
   input  stream_pkg::beat_t wr_beat,
   input  logic              wr_en,
   output logic              wr_ready,
   input  logic              rd_en,
   output stream_pkg::beat_t rd_beat,
   output logic              empty,
   output logic              nearly_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   stream_pkg::beat_t mem [DEPTH];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   // Write only while at least two entries are free
   assign nearly_full = count >= (DEPTH_BITS + 1)'(DEPTH - 1);
   assign wr_ready    = !nearly_full;
   assign empty       = count == '0;

   assign do_wr = wr_en && wr_ready;
   assign do_rd = rd_en && !empty;

   // Head beat shows as soon as it is stored
   assign rd_beat = mem[rd_ptr];

   always_ff @(posedge axis_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_beat;
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   // A refused write must wait with the same beat
   a_no_overflow : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      wr_en && !wr_ready |=> wr_en && $stable(wr_beat));

   // Consumer pops only a beat it was shown
   a_no_underflow : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      rd_en |-> !empty);

endmodule

// ==== verilog/packet_steer.sv ====
// ====================
// Packet steering FSM
// Classification, metadata beat and output mux
// ====================
`timescale 1ns/1ps
`include "arp_dma_config.svh"

module packet_steer (
   input  logic                axis_aclk,
   input  logic                axis_resetn,
   input  stream_pkg::beat_t   in_beat,
   input  logic                in_empty,
   output logic                in_rd,
   output stream_pkg::beat_t   dma_beat,
   output logic                dma_wr,
   input  stream_pkg::beat_t   dma_head,
   input  logic                dma_empty,
   output logic                dma_rd,
   output stream_pkg::beat_t   out_beat,
   output logic                out_valid,
   input  logic                out_ready,
   input  ctrl_pkg::reg_word_t size_bytes
);

   ctrl_pkg::steer_state_e state;
   ctrl_pkg::steer_state_e next_state;

   stream_pkg::port_t       src_port;
   stream_pkg::ether_type_t ether_type;
   stream_pkg::user_t       arp_user;
   stream_pkg::beat_t       meta_beat;
   logic                    arp_tail;
   logic                    arp_capture;

   assign src_port   = in_beat.user[`SRC_PORT_LSB +: $bits(stream_pkg::port_t)];
   assign ether_type = in_beat.data[`TYPE_LSB +: $bits(stream_pkg::ether_type_t)];

   // Payload packets go to the buffer unchanged
   assign dma_beat = in_beat;

   // Metadata beat: magic low, size above, sideband of the ARP head
   always_comb begin
      meta_beat             = '0;
      meta_beat.data[31:0]  = `META_MAGIC;
      meta_beat.data[63:32] = size_bytes;
      meta_beat.keep        = '1;
      meta_beat.user        = arp_user;
      meta_beat.last        = dma_empty;
   end

   always_comb begin
      next_state  = state;
      in_rd       = 1'b0;
      dma_wr      = 1'b0;
      dma_rd      = 1'b0;
      out_valid   = 1'b0;
      out_beat    = in_beat;
      arp_capture = 1'b0;

      case (state)
         ctrl_pkg::IDLE: begin
            if (!in_empty) begin
               if (src_port == `DMA_IDENT) begin
                  next_state = ctrl_pkg::DMA_STORE;
               end else begin
                  out_valid = 1'b1;
                  if (out_ready) begin
                     in_rd = 1'b1;
                     if (ether_type == `ARP_TYPE) begin
                        arp_capture = 1'b1;
                        next_state  = ctrl_pkg::ARP_META;
                     end else if (!in_beat.last) begin
                        next_state = ctrl_pkg::PASS;
                     end
                  end
               end
            end
         end
         ctrl_pkg::ARP_META: begin
            out_valid = 1'b1;
            out_beat  = meta_beat;
            if (out_ready) begin
               if (!dma_empty) begin
                  next_state = ctrl_pkg::ARP_PAYLOAD;
               end else if (arp_tail) begin
                  next_state = ctrl_pkg::DISCARD;
               end else begin
                  next_state = ctrl_pkg::IDLE;
               end
            end
         end
         ctrl_pkg::ARP_PAYLOAD: begin
            out_valid = !dma_empty;
            out_beat  = dma_head;
            if (!dma_empty && out_ready) begin
               dma_rd = 1'b1;
               if (dma_head.last) begin
                  next_state = arp_tail ? ctrl_pkg::DISCARD : ctrl_pkg::IDLE;
               end
            end
         end
         ctrl_pkg::DMA_STORE: begin
            if (!in_empty) begin
               in_rd  = 1'b1;
               dma_wr = 1'b1;
               if (in_beat.last) begin
                  next_state = ctrl_pkg::IDLE;
               end
            end
         end
         ctrl_pkg::PASS: begin
            out_valid = !in_empty;
            if (!in_empty && out_ready) begin
               in_rd = 1'b1;
               if (in_beat.last) begin
                  next_state = ctrl_pkg::IDLE;
               end
            end
         end
         ctrl_pkg::DISCARD: begin
            // Rest of the ARP packet is dropped
            if (!in_empty) begin
               in_rd = 1'b1;
               if (in_beat.last) begin
                  next_state = ctrl_pkg::IDLE;
               end
            end
         end
         default: begin
            next_state = ctrl_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         state    <= ctrl_pkg::IDLE;
         arp_tail <= 1'b0;
      end else begin
         state <= next_state;
         if (arp_capture) begin
            arp_tail <= !in_beat.last;
         end
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (arp_capture) begin
         arp_user <= in_beat.user;
      end
   end

   // Offered beat holds until the sink takes it
   a_out_stable : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// ==== verilog/ctrl_regs.sv ====
// ====================
// Four-phase register port
// Size register, packet in/out counters
// ====================
`timescale 1ns/1ps

module ctrl_regs (
   input  logic                axis_aclk,
   input  logic                axis_resetn,
   input  logic                reg_req,
   input  ctrl_pkg::reg_cmd_t  reg_cmd,
   output logic                reg_ack,
   output ctrl_pkg::reg_word_t reg_rdata,
   output ctrl_pkg::reg_word_t size_bytes,
   input  logic                in_valid,
   input  logic                in_ready,
   input  logic                in_last,
   input  logic                out_valid,
   input  logic                out_ready,
   input  logic                out_last
);

   ctrl_pkg::reg_word_t pkt_in;
   ctrl_pkg::reg_word_t pkt_out;
   ctrl_pkg::reg_word_t read_value;
   logic                access;
   logic                wr_size;
   logic                wr_pkt_in;
   logic                wr_pkt_out;
   logic                in_done;
   logic                out_done;

   // One access per request while ack is still low
   assign access     = reg_req && !reg_ack;
   assign wr_size    = access && reg_cmd.write && reg_cmd.addr == ctrl_pkg::REG_SIZE;
   assign wr_pkt_in  = access && reg_cmd.write && reg_cmd.addr == ctrl_pkg::REG_PKT_IN;
   assign wr_pkt_out = access && reg_cmd.write && reg_cmd.addr == ctrl_pkg::REG_PKT_OUT;

   assign in_done  = in_valid && in_ready && in_last;
   assign out_done = out_valid && out_ready && out_last;

   always_comb begin
      case (reg_cmd.addr)
         ctrl_pkg::REG_SIZE:    read_value = size_bytes;
         ctrl_pkg::REG_PKT_IN:  read_value = pkt_in;
         ctrl_pkg::REG_PKT_OUT: read_value = pkt_out;
         default:               read_value = '0;
      endcase
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         reg_ack    <= 1'b0;
         size_bytes <= '0;
         pkt_in     <= '0;
         pkt_out    <= '0;
      end else begin
         if (access) begin
            reg_ack <= 1'b1;
         end else if (!reg_req) begin
            reg_ack <= 1'b0;
         end
         if (wr_size) begin
            size_bytes <= reg_cmd.wdata;
         end
         // Counters wrap and a write clears them
         if (wr_pkt_in) begin
            pkt_in <= '0;
         end else if (in_done) begin
            pkt_in <= pkt_in + 1'b1;
         end
         if (wr_pkt_out) begin
            pkt_out <= '0;
         end else if (out_done) begin
            pkt_out <= pkt_out + 1'b1;
         end
      end
   end

   // Value from before the access
   always_ff @(posedge axis_aclk) begin
      if (access) begin
         reg_rdata <= read_value;
      end
   end

   // A new request waits until the previous ack has dropped
   a_req_after_ack : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      $rose(reg_req) |-> !reg_ack);

endmodule

// ==== verilog/arp_dma_top.sv ====
// ====================
// ARP/DMA steering top level
// Input FIFO, payload buffer, FSM, registers
// ====================
`timescale 1ns/1ps
`include "arp_dma_config.svh"

module arp_dma_top (
   input  logic                axis_aclk,
   input  logic                axis_resetn,
   input  stream_pkg::data_t   s_axis_tdata,
   input  stream_pkg::keep_t   s_axis_tkeep,
   input  stream_pkg::user_t   s_axis_tuser,
   input  logic                s_axis_tlast,
   input  logic                s_axis_tvalid,
   output logic                s_axis_tready,
   output stream_pkg::data_t   m_axis_tdata,
   output stream_pkg::keep_t   m_axis_tkeep,
   output stream_pkg::user_t   m_axis_tuser,
   output logic                m_axis_tlast,
   output logic                m_axis_tvalid,
   input  logic                m_axis_tready,
   input  logic                reg_req,
   input  ctrl_pkg::reg_cmd_t  reg_cmd,
   output logic                reg_ack,
   output ctrl_pkg::reg_word_t reg_rdata
);

   stream_pkg::beat_t   s_beat;
   stream_pkg::beat_t   in_beat;
   stream_pkg::beat_t   dma_beat;
   stream_pkg::beat_t   dma_head;
   stream_pkg::beat_t   out_beat;
   logic                in_empty;
   logic                in_rd;
   logic                dma_wr;
   logic                dma_rd;
   logic                dma_empty;
   ctrl_pkg::reg_word_t size_bytes;

   assign s_beat = {s_axis_tlast, s_axis_tuser, s_axis_tkeep, s_axis_tdata};

   assign m_axis_tdata = out_beat.data;
   assign m_axis_tkeep = out_beat.keep;
   assign m_axis_tuser = out_beat.user;
   assign m_axis_tlast = out_beat.last;

   stream_fifo #(.DEPTH_BITS(`IN_DEPTH_BITS)) in_fifo (
      .axis_aclk, .axis_resetn,
      .wr_beat(s_beat), .wr_en(s_axis_tvalid), .wr_ready(s_axis_tready),
      .rd_en(in_rd), .rd_beat(in_beat), .empty(in_empty), .nearly_full()
   );

   // Holds payload packets until an ARP request fetches them
   stream_fifo #(.DEPTH_BITS(`DMA_DEPTH_BITS)) dma_buffer (
      .axis_aclk, .axis_resetn,
      .wr_beat(dma_beat), .wr_en(dma_wr), .wr_ready(),
      .rd_en(dma_rd), .rd_beat(dma_head), .empty(dma_empty), .nearly_full()
   );

   packet_steer packet_steer (
      .axis_aclk, .axis_resetn,
      .in_beat, .in_empty, .in_rd,
      .dma_beat, .dma_wr, .dma_head, .dma_empty, .dma_rd,
      .out_beat, .out_valid(m_axis_tvalid), .out_ready(m_axis_tready),
      .size_bytes
   );

   ctrl_regs ctrl_regs (
      .axis_aclk, .axis_resetn,
      .reg_req, .reg_cmd, .reg_ack, .reg_rdata, .size_bytes,
      .in_valid(s_axis_tvalid), .in_ready(s_axis_tready), .in_last(s_axis_tlast),
      .out_valid(m_axis_tvalid), .out_ready(m_axis_tready), .out_last(m_axis_tlast)
   );

endmodule

// ==== tests/arp_dma_tb.sv ====
// ====================
// Testbench of the ARP/DMA steering block
// Stimulus, reference model, monitor, watchdog
// ====================
`timescale 1ns/1ps
`include "arp_dma_config.svh"

module arp_dma_tb;

   localparam int HALF_PERIOD = 10;
   localparam int KIND_NORMAL = 0;
   localparam int KIND_ARP    = 1;
   localparam int KIND_DMA    = 2;
   localparam ctrl_pkg::reg_word_t SIZE_A = 32'h0000_0040;
   localparam ctrl_pkg::reg_word_t SIZE_D = 32'h0000_1234;

   logic                axis_aclk;
   logic                axis_resetn;
   stream_pkg::data_t   s_axis_tdata;
   stream_pkg::keep_t   s_axis_tkeep;
   stream_pkg::user_t   s_axis_tuser;
   logic                s_axis_tlast;
   logic                s_axis_tvalid;
   logic                s_axis_tready;
   stream_pkg::data_t   m_axis_tdata;
   stream_pkg::keep_t   m_axis_tkeep;
   stream_pkg::user_t   m_axis_tuser;
   logic                m_axis_tlast;
   logic                m_axis_tvalid;
   logic                m_axis_tready;
   logic                reg_req;
   ctrl_pkg::reg_cmd_t  reg_cmd;
   logic                reg_ack;
   ctrl_pkg::reg_word_t reg_rdata;

   integer            seed;
   stream_pkg::beat_t pkt_q[$];
   stream_pkg::beat_t exp_q[$];
   // Payload packets the model holds for later ARP requests
   stream_pkg::beat_t model_dma[$];
   int                beat_mark[4];
   int                exp_mark[4];
   int                pkt_mark[4];
   int                n_pkts = 0;
   int                total_beats = 0;
   int                out_seen = 0;
   logic              saw_backpressure = 1'b0;
   logic              stim_ready = 1'b0;
   logic              random_ready = 1'b0;

   arp_dma_top arp_dma_top_i (
      .axis_aclk, .axis_resetn,
      .s_axis_tdata, .s_axis_tkeep, .s_axis_tuser, .s_axis_tlast,
      .s_axis_tvalid, .s_axis_tready,
      .m_axis_tdata, .m_axis_tkeep, .m_axis_tuser, .m_axis_tlast,
      .m_axis_tvalid, .m_axis_tready,
      .reg_req, .reg_cmd, .reg_ack, .reg_rdata
   );

   initial begin
      axis_aclk = 1'b0;
      forever #HALF_PERIOD axis_aclk = ~axis_aclk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   // Expected outputs of one input packet by the steering rules
   function automatic void predict_packet(input int first, input int len,
                                          input ctrl_pkg::reg_word_t size);
      stream_pkg::beat_t head;
      stream_pkg::beat_t meta;
      stream_pkg::beat_t b;
      logic              done;
      head = pkt_q[first];
      if (head.user[`SRC_PORT_LSB +: 8] == `DMA_IDENT) begin
         for (int i = 0; i < len; i++) begin
            model_dma.push_back(pkt_q[first + i]);
         end
      end else if (head.data[`TYPE_LSB +: 16] == `ARP_TYPE) begin
         exp_q.push_back(head);
         meta = '0;
         meta.data[31:0]  = `META_MAGIC;
         meta.data[63:32] = size;
         meta.keep = '1;
         meta.user = head.user;
         meta.last = model_dma.size() == 0;
         exp_q.push_back(meta);
         done = model_dma.size() == 0;
         while (!done) begin
            b = model_dma.pop_front();
            exp_q.push_back(b);
            done = b.last;
         end
      end else begin
         for (int i = 0; i < len; i++) begin
            exp_q.push_back(pkt_q[first + i]);
         end
      end
   endfunction

   function automatic int count_lasts(input int from, input int to);
      int n;
      n = 0;
      for (int i = from; i < to; i++) begin
         if (exp_q[i].last) begin
            n++;
         end
      end
      return n;
   endfunction

   task automatic add_packet(input int kind, input int len, input ctrl_pkg::reg_word_t size);
      stream_pkg::beat_t b;
      int                first;
      first = pkt_q.size();
      for (int i = 0; i < len; i++) begin
         b.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
         b.keep = stream_pkg::keep_t'($random(seed));
         b.user = $random(seed);
         b.last = i == len - 1;
         if (i == 0) begin
            // Port FF wins even over an ARP EtherType
            b.user[`SRC_PORT_LSB +: 8] = (kind == KIND_DMA) ? `DMA_IDENT :
                                         stream_pkg::port_t'({$random(seed)} % 255);
            b.data[`TYPE_LSB +: 16] = (kind == KIND_NORMAL) ? 16'h0008 : `ARP_TYPE;
         end
         pkt_q.push_back(b);
      end
      n_pkts++;
      predict_packet(first, len, size);
   endtask

   task automatic mark_phase(input int k);
      beat_mark[k] = pkt_q.size();
      exp_mark[k]  = exp_q.size();
      pkt_mark[k]  = n_pkts;
   endtask

   task automatic build_stimulus();
      int kinds[4];
      kinds = '{KIND_NORMAL, KIND_DMA, KIND_NORMAL, KIND_ARP};
      for (int i = 0; i < 8; i++) begin
         add_packet(KIND_NORMAL, 1 + int'({$random(seed)} % 5), SIZE_A);
      end
      mark_phase(0);
      // ARP requests while the payload buffer is empty
      add_packet(KIND_ARP, 1, SIZE_A);
      add_packet(KIND_ARP, 3, SIZE_A);
      add_packet(KIND_NORMAL, 2, SIZE_A);
      mark_phase(1);
      add_packet(KIND_DMA, 3, SIZE_A);
      add_packet(KIND_DMA, 1, SIZE_A);
      add_packet(KIND_NORMAL, 2, SIZE_A);
      add_packet(KIND_ARP, 4, SIZE_A);
      add_packet(KIND_ARP, 1, SIZE_A);
      add_packet(KIND_NORMAL, 1, SIZE_A);
      mark_phase(2);
      for (int i = 0; i < 12; i++) begin
         add_packet(kinds[i % 4], 1 + int'({$random(seed)} % 5), SIZE_D);
      end
      add_packet(KIND_ARP, 2, SIZE_D);
      mark_phase(3);
      total_beats = pkt_q.size();
   endtask

   task automatic send_beats(input int from, input int to);
      for (int i = from; i < to; i++) begin
         @(negedge axis_aclk);
         s_axis_tdata  = pkt_q[i].data;
         s_axis_tkeep  = pkt_q[i].keep;
         s_axis_tuser  = pkt_q[i].user;
         s_axis_tlast  = pkt_q[i].last;
         s_axis_tvalid = 1'b1;
         do @(posedge axis_aclk); while (!s_axis_tready);
      end
      @(negedge axis_aclk);
      s_axis_tvalid = 1'b0;
   endtask

   task automatic wait_outputs(input int target);
      while (out_seen < target) begin
         @(posedge axis_aclk);
      end
   endtask

   // Four-phase request returning the value read back
   task automatic reg_access(input logic write, input ctrl_pkg::reg_addr_e addr,
                             input ctrl_pkg::reg_word_t wdata,
                             output ctrl_pkg::reg_word_t rdata);
      @(negedge axis_aclk);
      reg_cmd.write = write;
      reg_cmd.addr  = addr;
      reg_cmd.wdata = wdata;
      reg_req = 1'b1;
      do @(posedge axis_aclk); while (!reg_ack);
      @(negedge axis_aclk);
      rdata   = reg_rdata;
      reg_req = 1'b0;
      do @(posedge axis_aclk); while (reg_ack);
   endtask

   task automatic reg_write(input ctrl_pkg::reg_addr_e addr, input ctrl_pkg::reg_word_t value);
      ctrl_pkg::reg_word_t unused_rd;
      reg_access(1'b1, addr, value, unused_rd);
   endtask

   task automatic reg_read_check(input ctrl_pkg::reg_addr_e addr, input int exp,
                                 input string name);
      ctrl_pkg::reg_word_t rd;
      reg_access(1'b0, addr, '0, rd);
      check_value(name, 128'(rd), 128'(exp));
   endtask

   task automatic compare_beat(input stream_pkg::beat_t exp);
      check_value("m_axis_tdata", 128'(m_axis_tdata), 128'(exp.data));
      check_value("m_axis_tkeep", 128'(m_axis_tkeep), 128'(exp.keep));
      check_value("m_axis_tuser", 128'(m_axis_tuser), 128'(exp.user));
      check_value("m_axis_tlast", 128'(m_axis_tlast), 128'(exp.last));
   endtask

   // Output monitor comparing one beat per handshake
   always @(posedge axis_aclk) begin
      if (axis_resetn) begin
         if (random_ready && s_axis_tvalid && !s_axis_tready) begin
            saw_backpressure <= 1'b1;
         end
         if (m_axis_tvalid && m_axis_tready) begin
            if (out_seen >= exp_q.size()) begin
               fail_run("An output beat arrived when no more beats were expected");
            end else begin
               compare_beat(exp_q[out_seen]);
               out_seen <= out_seen + 1;
            end
         end
      end
   end

   // Sink ready goes random in the back-pressure phase
   initial begin
      m_axis_tready = 1'b1;
      forever begin
         @(negedge axis_aclk);
         if (random_ready) begin
            m_axis_tready = ($random(seed) % 2) != 0;
         end else begin
            m_axis_tready = 1'b1;
         end
      end
   end

   initial begin
      wait (stim_ready);
      repeat (total_beats * 20 + 2000) @(posedge axis_aclk);
      fail_run("Timeout: the testbench did not finish in the expected time");
   end

   initial begin
      seed          = 20;
      axis_resetn   = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tkeep  = '0;
      s_axis_tuser  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      reg_req       = 1'b0;
      reg_cmd       = '0;
      build_stimulus();
      stim_ready = 1'b1;
      repeat (10) @(negedge axis_aclk);
      axis_resetn = 1'b1;
      check_value("m_axis_tvalid", 128'(m_axis_tvalid), 128'(1'b0));
      check_value("s_axis_tready", 128'(s_axis_tready), 128'(1'b1));
      check_value("reg_ack", 128'(reg_ack), 128'(1'b0));
      reg_read_check(ctrl_pkg::REG_SIZE, 0, "reg_rdata size");
      reg_write(ctrl_pkg::REG_SIZE, SIZE_A);
      reg_read_check(ctrl_pkg::REG_SIZE, SIZE_A, "reg_rdata size");
      send_beats(0, beat_mark[0]);
      wait_outputs(exp_mark[0]);
      send_beats(beat_mark[0], beat_mark[1]);
      wait_outputs(exp_mark[1]);
      send_beats(beat_mark[1], beat_mark[2]);
      wait_outputs(exp_mark[2]);
      reg_read_check(ctrl_pkg::REG_PKT_IN, pkt_mark[2], "reg_rdata pkt_in");
      reg_read_check(ctrl_pkg::REG_PKT_OUT, count_lasts(0, exp_mark[2]), "reg_rdata pkt_out");
      reg_write(ctrl_pkg::REG_PKT_IN, '0);
      reg_write(ctrl_pkg::REG_PKT_OUT, '0);
      reg_read_check(ctrl_pkg::REG_PKT_IN, 0, "reg_rdata pkt_in");
      reg_read_check(ctrl_pkg::REG_PKT_OUT, 0, "reg_rdata pkt_out");
      reg_write(ctrl_pkg::REG_SIZE, SIZE_D);
      reg_read_check(ctrl_pkg::REG_SIZE, SIZE_D, "reg_rdata size");
      random_ready = 1'b1;
      send_beats(beat_mark[2], beat_mark[3]);
      wait_outputs(exp_mark[3]);
      random_ready = 1'b0;
      reg_read_check(ctrl_pkg::REG_PKT_IN, pkt_mark[3] - pkt_mark[2], "reg_rdata pkt_in");
      reg_read_check(ctrl_pkg::REG_PKT_OUT, count_lasts(exp_mark[2], exp_mark[3]),
                     "reg_rdata pkt_out");
      if (!saw_backpressure) begin
         fail_run("s_axis_tready never dropped while the output was stalled");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

// ==== arp_dma.f ====
+incdir+verilog
verilog/stream_pkg.sv
verilog/ctrl_pkg.sv
verilog/stream_fifo.sv
verilog/packet_steer.sv
verilog/ctrl_regs.sv
verilog/arp_dma_top.sv
tests/arp_dma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ARP/DMA testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module arp_dma_tb -f arp_dma.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Varp_dma_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q "NO ERRORS"; then
   exit 0
fi
exit 1
